/* hdl/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath and address width
`define XLEN 32

// register index width
`define REG_ADDR_W 5

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// commit credits held after reset
`define COMMIT_CREDITS 2

`endif

/* hdl/core_pkg.sv */
package core_pkg;

	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111
	} opcode_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		opcode_e    opcode;
	} b_fmt_t;

	// also covers the lui upper immediate, bits 31:12
	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		b_fmt_t b_fmt;
		j_fmt_t j_fmt;
	} inst_u;

	typedef struct packed {
		alu_op_e    alu_op;
		logic       use_imm;
		logic       is_branch;
		logic       is_jal;
		logic       is_jalr;
		logic       rd_we;
		logic [2:0] funct3;
	} ctrl_t;

endpackage

/* hdl/core_ifs.sv */
`timescale 1ns/1ps
`include "core_params.svh"

interface fetch_if import core_pkg::*; ();
	logic             valid;
	logic             ready;
	logic [`XLEN-1:0] pc;
	inst_u            inst;

	modport src (output valid, pc, inst, input ready);
	modport dst (input valid, pc, inst, output ready);
endinterface

interface dec_if import core_pkg::*; ();
	logic                   valid;
	logic                   ready;
	logic [`XLEN-1:0]       pc;
	ctrl_t                  ctrl;
	logic [`XLEN-1:0]       src1;
	logic [`XLEN-1:0]       src2;
	logic [`XLEN-1:0]       imm;
	logic [`REG_ADDR_W-1:0] rd;

	modport src (output valid, pc, ctrl, src1, src2, imm, rd, input ready);
	modport dst (input valid, pc, ctrl, src1, src2, imm, rd, output ready);
endinterface

interface exe_if ();
	logic                   valid;
	logic                   ready;
	logic [`XLEN-1:0]       pc;
	logic [`REG_ADDR_W-1:0] rd;
	logic                   rd_we;
	logic [`XLEN-1:0]       result;
	logic [`XLEN-1:0]       next_pc;

	modport src (output valid, pc, rd, rd_we, result, next_pc, input ready);
	modport dst (input valid, pc, rd, rd_we, result, next_pc, output ready);
endinterface

/* hdl/fetch_unit.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module fetch_unit import core_pkg::*; (
	input  logic             clock_i,
	input  logic             reset_i,
	output logic             fetch_req_o,
	output logic [`XLEN-1:0] fetch_addr_o,
	input  logic             inst_valid_i,
	input  inst_u            inst_i,
	input  logic             retire_i,
	input  logic [`XLEN-1:0] next_pc_i,
	fetch_if.src             fetch
);
	logic             started_q;
	logic             req_q;
	logic [`XLEN-1:0] pc_q;
	inst_u            word_q;
	logic             word_vld_q;
	logic             resp;

	assign resp = inst_valid_i & req_q; // only while a request is open
	assign fetch_req_o = req_q;
	assign fetch_addr_o = pc_q;

	// word goes straight on to decode, held here only if decode is busy
	assign fetch.valid = resp | word_vld_q;
	assign fetch.inst = word_vld_q ? word_q : inst_i;
	assign fetch.pc = pc_q;

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			started_q <= 1'b0;
			req_q <= 1'b0;
			pc_q <= `RESET_PC;
			word_vld_q <= 1'b0;
		end else begin
			started_q <= 1'b1;
			if (!started_q || retire_i)
				req_q <= 1'b1; // first fetch, or next after retirement
			else if (resp)
				req_q <= 1'b0;
			if (retire_i)
				pc_q <= next_pc_i;
			if (fetch.valid && fetch.ready)
				word_vld_q <= 1'b0;
			else if (resp)
				word_vld_q <= 1'b1;
		end
	end

	always_ff @(posedge clock_i) begin
		if (resp)
			word_q <= inst_i;
	end

	// a new request never overtakes a word decode has not taken yet
	assert property (@(posedge clock_i) disable iff (reset_i)
		$rose(fetch_req_o) |-> !word_vld_q);

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module decode_stage import core_pkg::*; (
	input  logic                   clock_i,
	input  logic                   reset_i,
	fetch_if.dst                   fetch,
	dec_if.src                     dec,
	input  logic                   wb_we_i,
	input  logic [`REG_ADDR_W-1:0] wb_rd_i,
	input  logic [`XLEN-1:0]       wb_data_i
);
	inst_u            inst;
	ctrl_t            ctrl;
	logic [`XLEN-1:0] imm;
	logic             kept;
	logic [`XLEN-1:0] rf_q [1:31]; // x0 is not stored

	assign inst = fetch.inst;
	assign fetch.ready = !dec.valid | dec.ready;

	always_comb begin
		ctrl = '0;
		ctrl.funct3 = inst.r_fmt.funct3;
		imm = '0;
		kept = 1'b1;
		case (inst.r_fmt.opcode)
			OPC_OP: begin
				ctrl.rd_we = 1'b1;
				case (inst.r_fmt.funct3)
					3'b000: ctrl.alu_op = inst.r_fmt.funct7[5] ? ALU_SUB : ALU_ADD;
					3'b001: ctrl.alu_op = ALU_SLL;
					3'b010: ctrl.alu_op = ALU_SLT;
					3'b100: ctrl.alu_op = ALU_XOR;
					3'b101: ctrl.alu_op = ALU_SRL;
					3'b110: ctrl.alu_op = ALU_OR;
					3'b111: ctrl.alu_op = ALU_AND;
					default: kept = 1'b0; // sltu
				endcase
				// sub is the only kept op with a non-zero funct7
				if (inst.r_fmt.funct7 != 7'b0 &&
					!(inst.r_fmt.funct3 == 3'b000 && inst.r_fmt.funct7 == 7'b0100000))
					kept = 1'b0;
			end
			OPC_OP_IMM: begin
				ctrl.rd_we = 1'b1;
				ctrl.use_imm = 1'b1;
				imm = {{(`XLEN-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
				case (inst.i_fmt.funct3)
					3'b000: ctrl.alu_op = ALU_ADD;
					3'b010: ctrl.alu_op = ALU_SLT;
					3'b100: ctrl.alu_op = ALU_XOR;
					3'b110: ctrl.alu_op = ALU_OR;
					3'b111: ctrl.alu_op = ALU_AND;
					default: kept = 1'b0; // shifts and sltiu
				endcase
			end
			OPC_LUI: begin
				ctrl.rd_we = 1'b1;
				ctrl.use_imm = 1'b1;
				ctrl.alu_op = ALU_PASS_B;
				imm = {inst.j_fmt.imm20, inst.j_fmt.imm10_1, inst.j_fmt.imm11,
					inst.j_fmt.imm19_12, 12'b0};
			end
			OPC_BRANCH: begin
				imm = {{(`XLEN-12){inst.b_fmt.imm12}}, inst.b_fmt.imm11,
					inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
				kept = inst.b_fmt.funct3 inside {3'b000, 3'b001, 3'b100, 3'b101};
				ctrl.is_branch = kept;
			end
			OPC_JAL: begin
				ctrl.rd_we = 1'b1;
				ctrl.is_jal = 1'b1;
				imm = {{(`XLEN-20){inst.j_fmt.imm20}}, inst.j_fmt.imm19_12,
					inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};
			end
			OPC_JALR: begin
				ctrl.rd_we = 1'b1;
				imm = {{(`XLEN-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
				kept = inst.i_fmt.funct3 == 3'b000;
				ctrl.is_jalr = kept;
			end
			default: kept = 1'b0;
		endcase
		ctrl.rd_we = ctrl.rd_we & kept & (inst.r_fmt.rd != '0); // x0 and unknown words
	end

	always_ff @(posedge clock_i) begin
		if (wb_we_i && wb_rd_i != '0)
			rf_q[wb_rd_i] <= wb_data_i;
	end

	always_ff @(posedge clock_i) begin
		if (reset_i)
			dec.valid <= 1'b0;
		else if (fetch.valid && fetch.ready)
			dec.valid <= 1'b1;
		else if (dec.ready)
			dec.valid <= 1'b0;
	end

	// registered read, x0 reads zero
	always_ff @(posedge clock_i) begin
		if (fetch.valid && fetch.ready) begin
			dec.pc <= fetch.pc;
			dec.ctrl <= ctrl;
			dec.imm <= imm;
			dec.rd <= inst.r_fmt.rd;
			dec.src1 <= (inst.r_fmt.rs1 == '0) ? '0 : rf_q[inst.r_fmt.rs1];
			dec.src2 <= (inst.r_fmt.rs2 == '0) ? '0 : rf_q[inst.r_fmt.rs2];
		end
	end

endmodule

/* hdl/execute_stage.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module execute_stage import core_pkg::*; (
	input  logic clock_i,
	input  logic reset_i,
	dec_if.dst   dec,
	exe_if.src   exe
);
	localparam int SHAMT_W = $clog2(`XLEN);

	logic [`XLEN-1:0] op_a;
	logic [`XLEN-1:0] op_b;
	logic [`XLEN-1:0] alu_res;
	logic [`XLEN-1:0] pc_plus4;
	logic [`XLEN-1:0] next_pc;
	logic             lt;
	logic             taken;

	assign op_a = dec.src1;
	assign op_b = dec.ctrl.use_imm ? dec.imm : dec.src2;
	assign lt = $signed(op_a) < $signed(op_b);
	assign pc_plus4 = dec.pc + `XLEN'(4);
	assign dec.ready = !exe.valid | exe.ready;

	always_comb begin
		case (dec.ctrl.alu_op)
			ALU_ADD:    alu_res = op_a + op_b;
			ALU_SUB:    alu_res = op_a - op_b;
			ALU_AND:    alu_res = op_a & op_b;
			ALU_OR:     alu_res = op_a | op_b;
			ALU_XOR:    alu_res = op_a ^ op_b;
			ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, lt};
			ALU_SLL:    alu_res = op_a << op_b[SHAMT_W-1:0];
			ALU_SRL:    alu_res = op_a >> op_b[SHAMT_W-1:0];
			ALU_PASS_B: alu_res = op_b; // lui
			default:    alu_res = '0;
		endcase
	end

	// branches compare rs1 against rs2, never the immediate
	always_comb begin
		case (dec.ctrl.funct3)
			3'b000:  taken = dec.src1 == dec.src2;
			3'b001:  taken = dec.src1 != dec.src2;
			3'b100:  taken = $signed(dec.src1) < $signed(dec.src2);
			3'b101:  taken = $signed(dec.src1) >= $signed(dec.src2);
			default: taken = 1'b0;
		endcase
		taken = taken & dec.ctrl.is_branch;
	end

	always_comb begin
		if (dec.ctrl.is_jalr)
			next_pc = (dec.src1 + dec.imm) & ~`XLEN'(1);
		else if (taken || dec.ctrl.is_jal)
			next_pc = dec.pc + dec.imm;
		else
			next_pc = pc_plus4;
	end

	always_ff @(posedge clock_i) begin
		if (reset_i)
			exe.valid <= 1'b0;
		else if (dec.valid && dec.ready)
			exe.valid <= 1'b1;
		else if (exe.ready)
			exe.valid <= 1'b0;
	end

	always_ff @(posedge clock_i) begin
		if (dec.valid && dec.ready) begin
			exe.pc <= dec.pc;
			exe.rd <= dec.rd;
			exe.rd_we <= dec.ctrl.rd_we;
			exe.result <= (dec.ctrl.is_jal || dec.ctrl.is_jalr) ? pc_plus4 : alu_res;
			exe.next_pc <= next_pc;
		end
	end

endmodule

/* hdl/commit_stage.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module commit_stage (
	input  logic                   clock_i,
	input  logic                   reset_i,
	exe_if.dst                     exe,
	output logic                   commit_valid_o,
	output logic [`XLEN-1:0]       commit_pc_o,
	output logic                   commit_we_o,
	output logic [`REG_ADDR_W-1:0] commit_rd_o,
	output logic [`XLEN-1:0]       commit_data_o,
	input  logic                   commit_credit_i,
	output logic                   wb_we_o,
	output logic [`REG_ADDR_W-1:0] wb_rd_o,
	output logic [`XLEN-1:0]       wb_data_o,
	output logic                   retire_o,
	output logic [`XLEN-1:0]       next_pc_o
);
	localparam int CW = $clog2(`COMMIT_CREDITS + 1);

	logic                   held_q;
	logic [`XLEN-1:0]       pc_q;
	logic [`REG_ADDR_W-1:0] rd_q;
	logic                   we_q;
	logic [`XLEN-1:0]       data_q;
	logic [`XLEN-1:0]       npc_q;
	logic [CW-1:0]          credits_q;
	logic                   fire;

	assign exe.ready = !held_q;
	assign fire = held_q & (credits_q != '0); // waits here with no credit

	assign commit_valid_o = fire;
	assign commit_pc_o = pc_q;
	assign commit_we_o = we_q;
	assign commit_rd_o = rd_q;
	assign commit_data_o = data_q;
	assign wb_we_o = fire & we_q;
	assign wb_rd_o = rd_q;
	assign wb_data_o = data_q;
	assign retire_o = fire;
	assign next_pc_o = npc_q;

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			held_q <= 1'b0;
			credits_q <= CW'(`COMMIT_CREDITS);
		end else begin
			if (exe.valid && exe.ready)
				held_q <= 1'b1;
			else if (fire)
				held_q <= 1'b0;
			credits_q <= credits_q + CW'(commit_credit_i) - CW'(fire);
		end
	end

	always_ff @(posedge clock_i) begin
		if (exe.valid && exe.ready) begin
			pc_q <= exe.pc;
			rd_q <= exe.rd;
			we_q <= exe.rd_we;
			data_q <= exe.result;
			npc_q <= exe.next_pc;
		end
	end

	// returned credits never exceed what was spent
	assert property (@(posedge clock_i) disable iff (reset_i)
		credits_q <= CW'(`COMMIT_CREDITS));

endmodule

/* hdl/core_top.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module core_top (
	input  logic                   clock,
	input  logic                   reset,
	output logic                   fetch_req_o,
	output logic [`XLEN-1:0]       fetch_addr_o,
	input  logic                   inst_valid_i,
	input  logic [31:0]            inst_i,
	output logic                   commit_valid_o,
	output logic [`XLEN-1:0]       commit_pc_o,
	output logic                   commit_we_o,
	output logic [`REG_ADDR_W-1:0] commit_rd_o,
	output logic [`XLEN-1:0]       commit_data_o,
	input  logic                   commit_credit_i
);
	logic                   wb_we;
	logic [`REG_ADDR_W-1:0] wb_rd;
	logic [`XLEN-1:0]       wb_data;
	logic                   retire;
	logic [`XLEN-1:0]       next_pc;

	fetch_if fetch_bus ();
	dec_if   dec_bus ();
	exe_if   exe_bus ();

	fetch_unit u_fetch (
		.clock_i      (clock),
		.reset_i      (reset),
		.fetch_req_o  (fetch_req_o),
		.fetch_addr_o (fetch_addr_o),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.retire_i     (retire),
		.next_pc_i    (next_pc),
		.fetch        (fetch_bus.src)
	);

	decode_stage u_decode (
		.clock_i   (clock),
		.reset_i   (reset),
		.fetch     (fetch_bus.dst),
		.dec       (dec_bus.src),
		.wb_we_i   (wb_we),
		.wb_rd_i   (wb_rd),
		.wb_data_i (wb_data)
	);

	execute_stage u_execute (
		.clock_i (clock),
		.reset_i (reset),
		.dec     (dec_bus.dst),
		.exe     (exe_bus.src)
	);

	commit_stage u_commit (
		.clock_i         (clock),
		.reset_i         (reset),
		.exe             (exe_bus.dst),
		.commit_valid_o  (commit_valid_o),
		.commit_pc_o     (commit_pc_o),
		.commit_we_o     (commit_we_o),
		.commit_rd_o     (commit_rd_o),
		.commit_data_o   (commit_data_o),
		.commit_credit_i (commit_credit_i),
		.wb_we_o         (wb_we),
		.wb_rd_o         (wb_rd),
		.wb_data_o       (wb_data),
		.retire_o        (retire),
		.next_pc_o       (next_pc)
	);

endmodule

/* verif/iss_model.svh */
`ifndef ISS_MODEL_SVH
`define ISS_MODEL_SVH

logic [`XLEN-1:0] model_pc;
logic [`XLEN-1:0] model_rf [0:31];

task automatic reset_model();
	model_pc = `RESET_PC;
	for (int i = 0; i < 32; i++)
		model_rf[i] = '0;
endtask

// steps one instruction, returns what its retirement should show
task automatic predict_retire(input inst_u w, output logic [`XLEN-1:0] pc,
	output logic we, output logic [4:0] rd, output logic [`XLEN-1:0] data);
	logic [`XLEN-1:0] a;
	logic [`XLEN-1:0] b;
	logic [`XLEN-1:0] imm;
	logic [`XLEN-1:0] npc;
	logic kept;
	logic writes;
	a = (w.r_fmt.rs1 == 5'd0) ? '0 : model_rf[w.r_fmt.rs1];
	b = (w.r_fmt.rs2 == 5'd0) ? '0 : model_rf[w.r_fmt.rs2];
	npc = model_pc + 32'd4;
	data = '0;
	kept = 1'b1;
	writes = 1'b1;
	imm = {{20{w.i_fmt.imm[11]}}, w.i_fmt.imm};
	case (w.r_fmt.opcode)
		OPC_OP: case ({w.r_fmt.funct7, w.r_fmt.funct3})
			{7'h00, 3'd0}: data = a + b;
			{7'h20, 3'd0}: data = a - b;
			{7'h00, 3'd7}: data = a & b;
			{7'h00, 3'd6}: data = a | b;
			{7'h00, 3'd4}: data = a ^ b;
			{7'h00, 3'd2}: data = {31'd0, $signed(a) < $signed(b)};
			{7'h00, 3'd1}: data = a << b[4:0];
			{7'h00, 3'd5}: data = a >> b[4:0];
			default: kept = 1'b0;
		endcase
		OPC_OP_IMM: case (w.i_fmt.funct3)
			3'd0: data = a + imm;
			3'd2: data = {31'd0, $signed(a) < $signed(imm)};
			3'd4: data = a ^ imm;
			3'd6: data = a | imm;
			3'd7: data = a & imm;
			default: kept = 1'b0;
		endcase
		OPC_LUI: data = {w[31:12], 12'd0};
		OPC_BRANCH: begin
			writes = 1'b0;
			imm = {{20{w.b_fmt.imm12}}, w.b_fmt.imm11, w.b_fmt.imm10_5, w.b_fmt.imm4_1, 1'b0};
			case (w.b_fmt.funct3)
				3'd0: if (a == b) npc = model_pc + imm;
				3'd1: if (a != b) npc = model_pc + imm;
				3'd4: if ($signed(a) < $signed(b)) npc = model_pc + imm;
				3'd5: if ($signed(a) >= $signed(b)) npc = model_pc + imm;
				default: kept = 1'b0;
			endcase
		end
		OPC_JAL: begin
			data = model_pc + 32'd4;
			npc = model_pc + {{12{w.j_fmt.imm20}}, w.j_fmt.imm19_12, w.j_fmt.imm11,
				w.j_fmt.imm10_1, 1'b0};
		end
		OPC_JALR: begin
			kept = w.i_fmt.funct3 == 3'd0;
			data = model_pc + 32'd4;
			if (kept)
				npc = (a + imm) & ~32'd1;
		end
		default: kept = 1'b0;
	endcase
	if (!kept)
		npc = model_pc + 32'd4; // unknown word is a no-op
	rd = w.r_fmt.rd;
	we = kept & writes & (rd != 5'd0);
	if (we)
		model_rf[rd] = data;
	pc = model_pc;
	model_pc = npc;
endtask

`endif

/* verif/core_tb.sv */
`timescale 1ns/1ps
`include "core_params.svh"

module core_tb import core_pkg::*; ();
	logic clock;
	logic reset;
	logic fetch_req_o;
	logic [`XLEN-1:0] fetch_addr_o;
	logic inst_valid_i;
	logic [31:0] inst_i;
	logic commit_valid_o;
	logic [`XLEN-1:0] commit_pc_o;
	logic commit_we_o;
	logic [`REG_ADDR_W-1:0] commit_rd_o;
	logic [`XLEN-1:0] commit_data_o;
	logic commit_credit_i;

	logic [31:0] mem [0:255];
	string test_name = "reset";
	int cycle = 0;
	int retired = 0;
	int given = 0;
	int credits = `COMMIT_CREDITS;
	int inst_cyc = -10;
	int req_chk = -10;
	int errors = 0;
	int test_errs = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic seen_req = 1'b0;
	logic reset_d = 1'b1;
	logic withhold = 1'b0;
	logic returning = 1'b0;
	logic timed_out = 1'b0;

	`include "iss_model.svh"

	core_top dut (.*);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] gen_word();
		logic [31:0] r;
		logic [2:0] f3;
		logic [20:0] off;
		int kind;
		r = $urandom;
		off = 21'((int'($urandom % 33) - 16) * 4); // +-64 bytes
		kind = int'($urandom % 20);
		f3 = 3'($urandom % 8);
		if (kind < 6) begin
			if (f3 == 3'd3)
				f3 = 3'd0; // no sltu
			return {(f3 == 3'd0 && r[0]) ? 7'h20 : 7'h00, r[24:15], f3, r[11:7],
				7'b0110011};
		end
		if (kind < 11) begin
			if (f3 == 3'd1 || f3 == 3'd3 || f3 == 3'd5)
				f3 = 3'd0;
			return {r[31:15], f3, r[11:7], 7'b0010011};
		end
		if (kind == 11)
			return {r[31:7], 7'b0110111};
		if (kind < 15)
			return {off[12], off[10:5], r[24:15], f3[1], 1'b0, f3[0], off[4:1], off[11],
				7'b1100011}; // beq, bne, blt, bge
		if (kind < 17)
			return {off[20], off[10:1], off[11], off[19:12], r[11:7], 7'b1101111};
		if (kind == 17)
			return {2'b00, r[27:20], 2'b00, 5'd0, 3'd0, r[11:7], 7'b1100111};
		case (r[1:0]) // load, store, system, auipc
			2'd0: return {r[31:7], 7'b0000011};
			2'd1: return {r[31:7], 7'b0100011};
			2'd2: return {r[31:7], 7'b1110011};
			default: return {r[31:7], 7'b0010111};
		endcase
	endfunction

	task automatic compare_field(string what, logic [31:0] exp, logic [31:0] act);
		assert (exp === act) else begin
			$display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
			errors++;
			test_errs++;
		end
	endtask

	task automatic note_timeout(string msg);
		$display("%s in test %s", msg, test_name);
		timed_out = 1'b1;
		errors++;
		test_errs++;
	endtask

	task automatic wait_commits(int target);
		int idle;
		int last;
		idle = 0;
		last = retired;
		while (retired < target && idle < 200) begin
			@(negedge clock);
			idle = (retired != last) ? 0 : idle + 1;
			last = retired;
		end
		if (retired < target)
			note_timeout("timed out waiting for a retirement");
	endtask

	task automatic end_test();
		$display("test %s done with %0d errors", test_name, test_errs);
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		test_errs = 0;
	endtask

	// memory answers after 1 to 4 cycles
	initial begin
		int d;
		forever begin
			@(posedge clock);
			if (!reset && fetch_req_o) begin
				d = int'($urandom % 4);
				repeat (d) @(posedge clock);
				inst_valid_i <= 1'b1;
				inst_i <= mem[fetch_addr_o[9:2]];
				@(posedge clock);
				inst_valid_i <= 1'b0;
			end
		end
	end

	initial begin
		int d;
		forever begin
			@(posedge clock);
			if (!reset && !withhold && given < retired) begin
				returning = 1'b1;
				d = int'($urandom % 7);
				repeat (d) @(posedge clock);
				commit_credit_i <= 1'b1;
				given++;
				@(posedge clock);
				commit_credit_i <= 1'b0;
				returning = 1'b0;
			end
		end
	end

	always @(posedge clock) begin
		logic [`XLEN-1:0] e_pc;
		logic [`XLEN-1:0] e_data;
		logic [4:0] e_rd;
		logic e_we;
		cycle++;
		if ((reset || reset_d) && cycle > 1)
			assert (!fetch_req_o && !commit_valid_o) else begin
				$display("request or commit raised during reset");
				errors++;
				test_errs++;
			end
		if (reset) begin
			credits = `COMMIT_CREDITS;
		end else begin
			if (fetch_req_o && !seen_req) begin
				compare_field("first fetch_addr", `RESET_PC, fetch_addr_o);
				seen_req = 1'b1;
			end
			if (inst_valid_i)
				inst_cyc = cycle;
			if (cycle == inst_cyc + 3 && credits > 0)
				assert (commit_valid_o) else begin
					$display("commit did not come 3 cycles after the fetch response");
					errors++;
					test_errs++;
				end
			if (cycle == req_chk) begin
				assert (fetch_req_o) else begin
					$display("fetch request did not come 1 cycle after retirement");
					errors++;
					test_errs++;
				end
				compare_field("fetch_addr", model_pc, fetch_addr_o);
			end
			if (commit_valid_o) begin
				assert (credits > 0) else begin
					$display("retirement with no credit left");
					errors++;
					test_errs++;
				end
				predict_retire(mem[model_pc[9:2]], e_pc, e_we, e_rd, e_data);
				compare_field("commit_pc", e_pc, commit_pc_o);
				compare_field("commit_we", 32'(e_we), 32'(commit_we_o));
				if (e_we) begin
					compare_field("commit_rd", 32'(e_rd), 32'(commit_rd_o));
					compare_field("commit_data", e_data, commit_data_o);
				end
				retired <= retired + 1;
				req_chk = cycle + 1;
			end
			credits = credits - int'(commit_valid_o) + int'(commit_credit_i);
		end
		reset_d <= reset;
	end

	initial begin
		int idle;
		int count;
		reset = 1'b1;
		inst_valid_i = 1'b0;
		inst_i = '0;
		commit_credit_i = 1'b0;
		void'($urandom(17995));
		for (int i = 0; i < 256; i++) begin
			if (i < 31)
				mem[i] = {12'($urandom), 5'd0, 3'd0, 5'(i + 1), 7'b0010011}; // set x1..x31
			else
				mem[i] = gen_word();
		end
		reset_model();
		repeat (4) @(posedge clock);
		reset <= 1'b0;

		idle = 0;
		while (!seen_req && idle < 200) begin
			@(negedge clock);
			idle++;
		end
		if (!seen_req)
			note_timeout("no fetch request after reset");
		end_test();

		if (!timed_out) begin
			test_name = "retire_first";
			wait_commits(150);
			end_test();
		end

		if (!timed_out) begin
			test_name = "credit_stall";
			withhold = 1'b1;
			idle = 0;
			while ((credits != 0 || returning) && idle < 200) begin
				@(negedge clock);
				idle++;
			end
			if (credits != 0 || returning) begin
				note_timeout("credits never ran out while withheld");
			end else begin
				count = retired;
				repeat (20) @(negedge clock);
				assert (retired == count) else begin
					$display("retirement appeared while credits were withheld");
					errors++;
					test_errs++;
				end
				withhold = 1'b0;
				wait_commits(retired + 1);
			end
			end_test();
		end

		if (!timed_out) begin
			test_name = "retire_second";
			wait_commits(300);
			end_test();
		end

		$display("tests %0d failed %0d retirements %0d errors %0d",
			tests_run, tests_failed, retired, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* project.f */
+incdir+hdl
+incdir+verif
hdl/core_pkg.sv
hdl/core_ifs.sv
hdl/fetch_unit.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/commit_stage.sv
hdl/core_top.sv
verif/core_tb.sv

/* run.sh */
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f project.f --top-module core_tb -o core_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/core_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
fi
exit 1
